/* include/accum_rf_consts.svh */
`ifndef ACCUM_RF_CONSTS_SVH
`define ACCUM_RF_CONSTS_SVH

// architectural register number and reorder-buffer tag widths
`define ACC_REG_WIDTH 5
`define ACC_ROB_WIDTH 4

// cores feeding the accumulators and the number of accumulator lanes
`define ACC_N_CORE 4
`define ACC_N_LANE 3 // lane i owns register 32 - ACC_N_LANE + i

// age stamp is compared as a signed number
`define ACC_STAMP_WIDTH 8

// cycles from an accepted request to the accumulator write
`define ACC_LATENCY 4

// stack pointer register and its value out of reset
`define ACC_REG_SP 2
`define ACC_SP_INIT 32'h0000_f000

`endif

/* source/accum_rf_pkg.sv */
package accum_rf_pkg;

	`include "accum_rf_consts.svh"

	// one architectural register, also what a read port returns
	typedef struct packed {
		logic valid;
		logic [`ACC_ROB_WIDTH-1:0] tag;
		logic [31:0] data;
	} reg_entry_t;

	// request of one core to one accumulator lane
	typedef struct packed {
		logic valid;
		logic signed [`ACC_STAMP_WIDTH-1:0] stamp; // smaller is older
		logic [31:0] data;
	} acc_req_t;

	typedef struct packed {
		logic start; // request accepted this cycle
		logic [31:0] data;
		logic [$clog2(`ACC_N_CORE)-1:0] core;
	} lane_op_t;

	typedef struct packed {
		logic write;
		logic [31:0] sum;
	} lane_wb_t;

endpackage

/* source/acc_dispatch.sv */
`timescale 1ns/100ps
`include "accum_rf_consts.svh"

module acc_dispatch (
	input accum_rf_pkg::acc_req_t acc_req [`ACC_N_CORE][`ACC_N_LANE],
	input logic [`ACC_N_LANE-1:0] lane_can_accept,
	output logic acc_ready [`ACC_N_CORE][`ACC_N_LANE],
	output accum_rf_pkg::lane_op_t lane_op [`ACC_N_LANE],
	output logic no_acc_req
);
	import accum_rf_pkg::*;

	localparam int CORE_W = $clog2(`ACC_N_CORE);

	// true when the second request beats the first, ties stay with the first
	function automatic logic second_wins(acc_req_t first, acc_req_t second);
		return second.valid && (!first.valid || $signed(second.stamp) < $signed(first.stamp));
	endfunction

	for (genvar l = 0; l < `ACC_N_LANE; l++) begin : g_lane
		logic pick1; // core 1 beats core 0
		logic pick3; // core 3 beats core 2
		logic pick_hi;
		acc_req_t win01;
		acc_req_t win23;
		acc_req_t winner;
		logic [CORE_W-1:0] win_core;
		logic grant;

		assign pick1 = second_wins(acc_req[0][l], acc_req[1][l]);
		assign pick3 = second_wins(acc_req[2][l], acc_req[3][l]);
		assign win01 = pick1 ? acc_req[1][l] : acc_req[0][l];
		assign win23 = pick3 ? acc_req[3][l] : acc_req[2][l];

		// final round between the two pair winners
		assign pick_hi = second_wins(win01, win23);
		assign winner = pick_hi ? win23 : win01;
		assign win_core = pick_hi ? {1'b1, pick3} : {1'b0, pick1};

		assign grant = winner.valid && lane_can_accept[l];

		for (genvar c = 0; c < `ACC_N_CORE; c++) begin : g_ready
			assign acc_ready[c][l] = grant && win_core == CORE_W'(c);
		end

		// start equals valid && ready of the granted core
		assign lane_op[l] = '{start: grant, data: winner.data, core: win_core};
	end

	always_comb begin
		no_acc_req = 1'b1;
		for (int c = 0; c < `ACC_N_CORE; c++) begin
			for (int l = 0; l < `ACC_N_LANE; l++) begin
				if (acc_req[c][l].valid) begin
					no_acc_req = 1'b0;
				end
			end
		end
	end

endmodule

/* source/acc_lane.sv */
`timescale 1ns/100ps
`include "accum_rf_consts.svh"

module acc_lane (
	input logic clk,
	input logic reset,
	input accum_rf_pkg::lane_op_t op,
	input logic [31:0] acc_value,
	output logic can_accept,
	output logic idle,
	output accum_rf_pkg::lane_wb_t wb
);
	localparam int CNT_W = $clog2(`ACC_LATENCY + 1);

	logic [CNT_W-1:0] count;
	logic [31:0] operand_a;
	logic [31:0] stage_a;
	logic [31:0] stage_b;
	logic [31:0] sum_pipe [`ACC_LATENCY-1];

	// at count 1 the register still holds the old value so the fresh sum is bypassed
	assign operand_a = (count == CNT_W'(1)) ? wb.sum : acc_value;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (op.start) begin
			count <= CNT_W'(`ACC_LATENCY);
		end else if (count != '0) begin
			count <= count - CNT_W'(1);
		end
	end

	// operand capture is the first of ACC_LATENCY register stages
	always_ff @(posedge clk) begin
		if (op.start) begin
			stage_a <= operand_a;
			stage_b <= op.data;
		end
		sum_pipe[0] <= stage_a + stage_b;
		for (int i = 1; i < `ACC_LATENCY - 1; i++) begin
			sum_pipe[i] <= sum_pipe[i-1];
		end
	end

	assign can_accept = count <= CNT_W'(1);
	assign idle = count == '0;

	// the register file takes the sum at the edge that ends count 1
	assign wb = '{write: count == CNT_W'(1), sum: sum_pipe[`ACC_LATENCY-2]};

endmodule

/* source/reg_scoreboard_file.sv */
`timescale 1ns/100ps
`include "accum_rf_consts.svh"

module reg_scoreboard_file (
	input logic clk,
	input logic reset,
	input logic issue,
	input logic [`ACC_REG_WIDTH-1:0] issue_reg,
	input logic [`ACC_ROB_WIDTH-1:0] issue_tag,
	input logic commit,
	input logic [`ACC_REG_WIDTH-1:0] commit_reg,
	input logic [`ACC_ROB_WIDTH-1:0] commit_tag,
	input logic [31:0] commit_data,
	input accum_rf_pkg::lane_wb_t lane_wb [`ACC_N_LANE],
	input logic [`ACC_N_LANE-1:0] lane_idle,
	input logic [`ACC_REG_WIDTH-1:0] read_reg [2],
	output accum_rf_pkg::reg_entry_t read_data [2],
	output logic [31:0] acc_value [`ACC_N_LANE],
	output logic all_lanes_idle
);
	import accum_rf_pkg::*;

	localparam int N_REG = 1 << `ACC_REG_WIDTH;
	localparam int ACC_BASE = N_REG - `ACC_N_LANE; // first accumulator register

	reg_entry_t regs [N_REG];

	for (genvar r = 0; r < N_REG; r++) begin : g_reg
		localparam logic [31:0] INIT_DATA = (r == `ACC_REG_SP) ? `ACC_SP_INIT : 32'h0;

		reg_entry_t entry;
		logic issue_hit;
		logic tag_match;
		logic data_hit;
		logic lane_wr;
		logic [31:0] lane_sum;

		assign issue_hit = issue && issue_reg == `ACC_REG_WIDTH'(r);
		assign tag_match = commit && entry.tag == commit_tag;
		// commit data lands only while the register still waits on that tag
		assign data_hit = tag_match && !entry.valid && !issue_hit &&
			commit_reg == `ACC_REG_WIDTH'(r);

		if (r >= ACC_BASE) begin : g_acc
			assign lane_wr = lane_wb[r-ACC_BASE].write;
			assign lane_sum = lane_wb[r-ACC_BASE].sum;
		end else begin : g_arch
			assign lane_wr = 1'b0;
			assign lane_sum = '0;
		end

		always_ff @(posedge clk) begin
			if (reset) begin
				entry <= '{valid: 1'b1, tag: '0, data: INIT_DATA};
			end else begin
				if (issue_hit) begin // a new issue hides any commit of the old tag
					entry.valid <= 1'b0;
					entry.tag <= issue_tag;
				end else if (tag_match) begin
					entry.valid <= 1'b1;
				end

				if (lane_wr) begin
					entry.data <= lane_sum;
				end else if (data_hit) begin
					entry.data <= commit_data;
				end
			end
		end

		assign regs[r] = entry;
	end

	for (genvar p = 0; p < 2; p++) begin : g_read
		assign read_data[p] = regs[read_reg[p]];
	end

	for (genvar l = 0; l < `ACC_N_LANE; l++) begin : g_acc_value
		assign acc_value[l] = regs[ACC_BASE+l].data;
	end

	assign all_lanes_idle = &lane_idle;

endmodule

/* source/accum_rf_top.sv */
`timescale 1ns/100ps
`include "accum_rf_consts.svh"

module accum_rf_top (
	input logic clk,
	input logic reset,
	input logic issue,
	input logic [`ACC_REG_WIDTH-1:0] issue_reg,
	input logic [`ACC_ROB_WIDTH-1:0] issue_tag,
	input logic commit,
	input logic [`ACC_REG_WIDTH-1:0] commit_reg,
	input logic [`ACC_ROB_WIDTH-1:0] commit_tag,
	input logic [31:0] commit_data,
	input logic [`ACC_REG_WIDTH-1:0] read_reg [2],
	output accum_rf_pkg::reg_entry_t read_data [2],
	input accum_rf_pkg::acc_req_t acc_req [`ACC_N_CORE][`ACC_N_LANE],
	output logic acc_ready [`ACC_N_CORE][`ACC_N_LANE],
	output logic all_lanes_idle,
	output logic no_acc_req
);
	import accum_rf_pkg::*;

	lane_op_t lane_op [`ACC_N_LANE];
	lane_wb_t lane_wb [`ACC_N_LANE];
	logic [31:0] acc_value [`ACC_N_LANE];
	logic [`ACC_N_LANE-1:0] lane_can_accept;
	logic [`ACC_N_LANE-1:0] lane_idle;

	acc_dispatch i_acc_dispatch (
		.acc_req(acc_req),
		.lane_can_accept(lane_can_accept),
		.acc_ready(acc_ready),
		.lane_op(lane_op),
		.no_acc_req(no_acc_req)
	);

	for (genvar l = 0; l < `ACC_N_LANE; l++) begin : g_lane
		acc_lane i_acc_lane (
			.clk(clk),
			.reset(reset),
			.op(lane_op[l]),
			.acc_value(acc_value[l]),
			.can_accept(lane_can_accept[l]),
			.idle(lane_idle[l]),
			.wb(lane_wb[l])
		);
	end

	reg_scoreboard_file i_reg_scoreboard_file (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.issue_reg(issue_reg),
		.issue_tag(issue_tag),
		.commit(commit),
		.commit_reg(commit_reg),
		.commit_tag(commit_tag),
		.commit_data(commit_data),
		.lane_wb(lane_wb),
		.lane_idle(lane_idle),
		.read_reg(read_reg),
		.read_data(read_data),
		.acc_value(acc_value),
		.all_lanes_idle(all_lanes_idle)
	);

endmodule

/* sim/accum_rf_tb.sv */
`timescale 1ns/100ps
`include "accum_rf_consts.svh"

module accum_rf_tb;
	import accum_rf_pkg::*;

	localparam int N_REG = 1 << `ACC_REG_WIDTH;
	localparam int ACC_BASE = N_REG - `ACC_N_LANE;
	localparam int TIMEOUT = 50;
	localparam int MAX_REQ = 8;

	typedef enum logic [2:0] {op_issue, op_commit, op_acc, op_check_reg, op_wait_idle} op_kind_t;

	// lane, core_mask, count and stamps only matter for op_acc rows
	typedef struct packed {
		op_kind_t op;
		int test;
		logic [`ACC_REG_WIDTH-1:0] reg_num;
		logic [`ACC_ROB_WIDTH-1:0] tag; // issue/commit tag, or expected tag of a check
		logic [31:0] data;
		logic exp_valid;
		int lane;
		logic [`ACC_N_CORE-1:0] core_mask;
		int count;
		logic [`ACC_N_CORE-1:0][`ACC_STAMP_WIDTH-1:0] stamps;
	} step_t;

	logic clk;
	logic reset;
	logic issue;
	logic [`ACC_REG_WIDTH-1:0] issue_reg;
	logic [`ACC_ROB_WIDTH-1:0] issue_tag;
	logic commit;
	logic [`ACC_REG_WIDTH-1:0] commit_reg;
	logic [`ACC_ROB_WIDTH-1:0] commit_tag;
	logic [31:0] commit_data;
	logic [`ACC_REG_WIDTH-1:0] read_reg [2];
	reg_entry_t read_data [2];
	acc_req_t acc_req [`ACC_N_CORE][`ACC_N_LANE];
	logic acc_ready [`ACC_N_CORE][`ACC_N_LANE];
	logic all_lanes_idle;
	logic no_acc_req;

	step_t steps [$];
	logic model_valid [N_REG];
	logic [`ACC_ROB_WIDTH-1:0] model_tag [N_REG];
	logic [31:0] model_data [N_REG];
	logic [31:0] pend_data [`ACC_N_CORE][`ACC_N_LANE][MAX_REQ];
	logic signed [`ACC_STAMP_WIDTH-1:0] pend_stamp [`ACC_N_CORE][`ACC_N_LANE];
	int pend_head [`ACC_N_CORE][`ACC_N_LANE];
	int pend_cnt [`ACC_N_CORE][`ACC_N_LANE];
	integer seed;
	int errors;
	int tests_run;
	int failed_tests;
	bit timed_out;
	string test_name [5];

	accum_rf_top i_accum_rf_top (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic report_error(string msg);
		$display("Error at %0t ns: %s", $time, msg);
		errors++;
	endtask

	function automatic void append_step(op_kind_t op, int test, int reg_num, int tag,
			logic [31:0] data, logic exp_valid);
		step_t s;
		s = '0;
		s.op = op;
		s.test = test;
		s.reg_num = `ACC_REG_WIDTH'(reg_num);
		s.tag = `ACC_ROB_WIDTH'(tag);
		s.data = data;
		s.exp_valid = exp_valid;
		steps.push_back(s);
	endfunction

	function automatic void add_burst(int test, int lane, logic [`ACC_N_CORE-1:0] core_mask,
			int count, logic [`ACC_N_CORE-1:0][`ACC_STAMP_WIDTH-1:0] stamps);
		step_t s;
		s = '0;
		s.op = op_acc;
		s.test = test;
		s.lane = lane;
		s.core_mask = core_mask;
		s.count = count;
		s.stamps = stamps;
		steps.push_back(s);
	endfunction

	function automatic void build_table();
		append_step(op_check_reg, 1, `ACC_REG_SP, 0, 32'h0, 1'b1);
		append_step(op_issue, 1, 5, 3, 32'h0, 1'b0);
		append_step(op_check_reg, 1, 5, 3, 32'h0, 1'b0);
		append_step(op_commit, 1, 5, 6, 32'h1111_2222, 1'b0); // wrong tag, stays pending
		append_step(op_check_reg, 1, 5, 3, 32'h0, 1'b0);
		append_step(op_commit, 1, 5, 3, 32'hdead_beef, 1'b0);
		append_step(op_check_reg, 1, 5, 3, 32'h0, 1'b1);
		append_step(op_issue, 2, 7, 4, 32'h0, 1'b0);
		append_step(op_issue, 2, 7, 9, 32'h0, 1'b0);
		append_step(op_commit, 2, 7, 4, 32'h0bad_0bad, 1'b0);
		append_step(op_check_reg, 2, 7, 9, 32'h0, 1'b0);
		append_step(op_commit, 2, 7, 9, 32'h5555_1234, 1'b0);
		append_step(op_check_reg, 2, 7, 9, 32'h0, 1'b1);
		// preload close to the top so the sum wraps
		append_step(op_issue, 3, ACC_BASE, 2, 32'h0, 1'b0);
		append_step(op_commit, 3, ACC_BASE, 2, 32'hffff_fff0, 1'b0);
		append_step(op_check_reg, 3, ACC_BASE, 2, 32'h0, 1'b1);
		add_burst(3, 0, 4'b0001, 6, '0);
		append_step(op_wait_idle, 3, 0, 0, 32'h0, 1'b0);
		append_step(op_check_reg, 3, ACC_BASE, 2, 32'h0, 1'b1);
		// stamps of cores 3..0 are -100, 5, -3, 5
		add_burst(4, 1, 4'b1111, 1, {8'h9c, 8'h05, 8'hfd, 8'h05});
		add_burst(4, 2, 4'b0100, 3, {8'h00, 8'h80, 8'h00, 8'h00});
		append_step(op_wait_idle, 4, 0, 0, 32'h0, 1'b0);
		append_step(op_check_reg, 4, ACC_BASE + 1, 0, 32'h0, 1'b1);
		append_step(op_check_reg, 4, ACC_BASE + 2, 0, 32'h0, 1'b1);
	endfunction

	task automatic compare_model(int p, int r);
		assert (read_data[p].valid == model_valid[r] && read_data[p].tag == model_tag[r]
				&& read_data[p].data == model_data[r])
		else report_error($sformatf("port %0d reg %0d read %b/%0d/%h, expected %b/%0d/%h", p, r,
				read_data[p].valid, read_data[p].tag, read_data[p].data, model_valid[r],
				model_tag[r], model_data[r]));
	endtask

	task automatic verify_reset_state();
		for (int r = 0; r < N_REG / 2; r++) begin
			read_reg[0] = `ACC_REG_WIDTH'(r);
			read_reg[1] = `ACC_REG_WIDTH'(r + N_REG / 2);
			#1;
			compare_model(0, r);
			compare_model(1, r + N_REG / 2);
			@(posedge clk);
			#2;
		end
		for (int c = 0; c < `ACC_N_CORE; c++) begin
			for (int l = 0; l < `ACC_N_LANE; l++) begin
				assert (!acc_ready[c][l]) else report_error($sformatf("ready high, core %0d", c));
			end
		end
		assert (all_lanes_idle && no_acc_req)
		else report_error("all_lanes_idle or no_acc_req low after reset");
	endtask

	task automatic drive_issue(step_t s);
		issue = 1'b1;
		issue_reg = s.reg_num;
		issue_tag = s.tag;
		@(posedge clk);
		#2;
		issue = 1'b0;
		model_valid[s.reg_num] = 1'b0;
		model_tag[s.reg_num] = s.tag;
	endtask

	task automatic send_commit(step_t s);
		commit = 1'b1;
		commit_reg = s.reg_num;
		commit_tag = s.tag;
		commit_data = s.data;
		@(posedge clk);
		#2;
		commit = 1'b0;
		if (!model_valid[s.reg_num] && model_tag[s.reg_num] == s.tag) begin
			model_data[s.reg_num] = s.data;
		end
		for (int r = 0; r < N_REG; r++) begin
			if (model_tag[r] == s.tag) model_valid[r] = 1'b1;
		end
	endtask

	task automatic check_register(step_t s);
		int other;
		other = N_REG - 1 - int'(s.reg_num);
		read_reg[0] = s.reg_num;
		read_reg[1] = `ACC_REG_WIDTH'(other);
		#1;
		assert (read_data[0].valid == s.exp_valid && read_data[0].tag == s.tag
				&& read_data[0].data == model_data[s.reg_num])
		else report_error($sformatf("reg %0d read %b/%0d/%h, expected %b/%0d/%h", s.reg_num,
				read_data[0].valid, read_data[0].tag, read_data[0].data, s.exp_valid, s.tag,
				model_data[s.reg_num]));
		compare_model(1, other);
		@(posedge clk);
		#2;
	endtask

	task automatic queue_burst(step_t s);
		logic [31:0] addend;
		for (int c = 0; c < `ACC_N_CORE; c++) begin
			if (s.core_mask[c]) begin
				pend_stamp[c][s.lane] = s.stamps[c];
				for (int k = 0; k < s.count; k++) begin
					addend = $random(seed);
					pend_data[c][s.lane][pend_cnt[c][s.lane]] = addend;
					pend_cnt[c][s.lane]++;
					model_data[ACC_BASE + s.lane] += addend; // wraps modulo 2^32
				end
			end
		end
	endtask

	function automatic bit any_pending();
		for (int c = 0; c < `ACC_N_CORE; c++) begin
			for (int l = 0; l < `ACC_N_LANE; l++) begin
				if (pend_head[c][l] < pend_cnt[c][l]) return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	// smallest signed stamp among waiting cores, lower index on a tie
	function automatic int oldest_core(int l);
		int best;
		best = -1;
		for (int c = 0; c < `ACC_N_CORE; c++) begin
			if (pend_head[c][l] < pend_cnt[c][l] &&
					(best < 0 || pend_stamp[c][l] < pend_stamp[best][l])) begin
				best = c;
			end
		end
		return best;
	endfunction

	task automatic drain_requests();
		int stall;
		int grants;
		int best;
		bit took [`ACC_N_CORE][`ACC_N_LANE];
		stall = 0;
		assert (no_acc_req) else report_error("no_acc_req low before any request");
		while (any_pending() && stall < TIMEOUT) begin
			for (int c = 0; c < `ACC_N_CORE; c++) begin
				for (int l = 0; l < `ACC_N_LANE; l++) begin
					acc_req[c][l].valid = pend_head[c][l] < pend_cnt[c][l];
					acc_req[c][l].stamp = pend_stamp[c][l];
					acc_req[c][l].data = pend_data[c][l][pend_head[c][l] % MAX_REQ];
				end
			end
			#1;
			assert (!no_acc_req) else report_error("no_acc_req high while requests are valid");
			stall++;
			for (int l = 0; l < `ACC_N_LANE; l++) begin
				grants = 0;
				best = oldest_core(l);
				for (int c = 0; c < `ACC_N_CORE; c++) begin
					took[c][l] = acc_ready[c][l];
					if (acc_ready[c][l]) begin
						grants++;
						stall = 0;
						assert (c == best)
						else report_error($sformatf("lane %0d granted core %0d, expected %0d",
								l, c, best));
					end
				end
				assert (grants <= 1) else report_error($sformatf("lane %0d granted twice", l));
			end
			@(posedge clk);
			#2;
			for (int c = 0; c < `ACC_N_CORE; c++) begin
				for (int l = 0; l < `ACC_N_LANE; l++) begin
					if (took[c][l] && pend_head[c][l] < pend_cnt[c][l]) pend_head[c][l]++;
				end
			end
		end
		if (any_pending()) begin
			$display("Timeout: requests still waiting for ready after %0d cycles", TIMEOUT);
			timed_out = 1'b1;
		end
		for (int c = 0; c < `ACC_N_CORE; c++) begin
			for (int l = 0; l < `ACC_N_LANE; l++) begin
				acc_req[c][l].valid = 1'b0;
				pend_head[c][l] = 0;
				pend_cnt[c][l] = 0;
			end
		end
		stall = 0;
		while (!all_lanes_idle && stall < TIMEOUT) begin
			@(posedge clk);
			#2;
			stall++;
		end
		if (!all_lanes_idle) begin
			$display("Timeout: lanes still busy after %0d cycles", TIMEOUT);
			timed_out = 1'b1;
		end
		#1;
		assert (no_acc_req) else report_error("no_acc_req low with no request valid");
		@(posedge clk);
		#2;
	endtask

	task automatic close_test(int t, int errs);
		tests_run++;
		if (errs == 0 && !timed_out) begin
			$display("test %0d (%s): ok", t, test_name[t]);
		end else begin
			$display("test %0d (%s): FAIL with %0d errors", t, test_name[t], errs);
			failed_tests++;
		end
	endtask

	initial begin
		int cur_test;
		int err_mark;
		seed = 32'heb9bea00;
		errors = 0;
		tests_run = 0;
		failed_tests = 0;
		timed_out = 1'b0;
		test_name = '{"reset state", "issue and commit", "reissue before commit",
				"single-core accumulate", "age arbitration"};
		reset = 1'b1;
		issue = 1'b0;
		issue_reg = '0;
		issue_tag = '0;
		commit = 1'b0;
		commit_reg = '0;
		commit_tag = '0;
		commit_data = '0;
		read_reg[0] = '0;
		read_reg[1] = '0;
		for (int c = 0; c < `ACC_N_CORE; c++) begin
			for (int l = 0; l < `ACC_N_LANE; l++) begin
				acc_req[c][l] = '0;
				pend_head[c][l] = 0;
				pend_cnt[c][l] = 0;
			end
		end
		for (int r = 0; r < N_REG; r++) begin
			model_valid[r] = 1'b1;
			model_tag[r] = '0;
			model_data[r] = (r == `ACC_REG_SP) ? `ACC_SP_INIT : 32'h0;
		end
		build_table();
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;
		verify_reset_state();
		close_test(0, errors);
		cur_test = 1;
		err_mark = errors;
		for (int i = 0; i < steps.size() && !timed_out; i++) begin
			if (steps[i].test != cur_test) begin
				close_test(cur_test, errors - err_mark);
				cur_test = steps[i].test;
				err_mark = errors;
			end
			case (steps[i].op)
				op_issue: drive_issue(steps[i]);
				op_commit: send_commit(steps[i]);
				op_acc: queue_burst(steps[i]);
				op_check_reg: check_register(steps[i]);
				op_wait_idle: drain_requests();
			endcase
		end
		close_test(cur_test, errors - err_mark);
		$display("%0d tests run, %0d failed, %0d errors", tests_run, failed_tests, errors);
		if (failed_tests == 0 && errors == 0 && !timed_out) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* accum_rf.f */
+incdir+include
source/accum_rf_pkg.sv
source/acc_dispatch.sv
source/acc_lane.sv
source/reg_scoreboard_file.sv
source/accum_rf_top.sv
sim/accum_rf_tb.sv

/* run_sim.sh */
#!/bin/bash
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f accum_rf.f --top-module accum_rf_tb \
	-Mdir obj_dir -o accum_rf_sim &&
	./obj_dir/accum_rf_sim > sim.log 2>&1 ||
	echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
